/* dv/exec_tb_ref.svh */
`ifndef EXEC_TB_REF_SVH
`define EXEC_TB_REF_SVH

typedef struct packed {
    logic        illegal;
    logic        wb;
    logic [31:0] wb_data;
    logic        jump;
    logic [31:0] jump_addr;
} exp_t;

// Expected outcome of one instruction, decoded from the RV32I bit layout
function automatic exp_t ref_result(input logic [31:0] instr, input logic [31:0] rs1,
                                    input logic [31:0] rs2, input logic [31:0] pc);
    exp_t        r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] imm_i;
    logic [31:0] b;
    r     = '0;
    f3    = instr[14:12];
    f7    = instr[31:25];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    b     = (instr[6:0] == OPC_OP) ? rs2 : imm_i;   // Second ALU operand
    case (instr[6:0])
        OPC_OP, OPC_OPIMM: begin
            if (instr[6:0] == OPC_OP) begin
                r.illegal = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
            end else begin
                r.illegal = (f3 == 3'd1 && f7 != 7'h00) ||
                            (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
            end
            case (f3)
                3'd0: r.wb_data = (instr[6:0] == OPC_OP && f7[5]) ? rs1 - b : rs1 + b;
                3'd1: r.wb_data = rs1 << b[4:0];
                3'd2: r.wb_data = {31'b0, $signed(rs1) < $signed(b)};
                3'd3: r.wb_data = {31'b0, rs1 < b};
                3'd4: r.wb_data = rs1 ^ b;
                3'd5: r.wb_data = f7[5] ? $unsigned($signed(rs1) >>> b[4:0]) : rs1 >> b[4:0];
                3'd6: r.wb_data = rs1 | b;
                default: r.wb_data = rs1 & b;
            endcase
            r.wb = 1'b1;
        end
        OPC_BRANCH: begin
            case (f3)
                3'd0: r.jump = (rs1 == rs2);
                3'd1: r.jump = (rs1 != rs2);
                3'd4: r.jump = ($signed(rs1) < $signed(rs2));
                3'd5: r.jump = ($signed(rs1) >= $signed(rs2));
                3'd6: r.jump = (rs1 < rs2);
                3'd7: r.jump = (rs1 >= rs2);
                default: r.illegal = 1'b1;
            endcase
            r.jump_addr = pc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                instr[11:8], 1'b0};
        end
        OPC_JAL: begin
            r.wb        = 1'b1;
            r.wb_data   = pc + 32'd4;
            r.jump      = 1'b1;
            r.jump_addr = pc + {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                instr[30:21], 1'b0};
        end
        OPC_JALR: begin
            r.illegal   = (f3 != 3'd0);
            r.wb        = 1'b1;
            r.wb_data   = pc + 32'd4;
            r.jump      = 1'b1;
            r.jump_addr = (rs1 + imm_i) & ~32'd1;
        end
        OPC_LUI: begin
            r.wb      = 1'b1;
            r.wb_data = {instr[31:12], 12'b0};
        end
        OPC_AUIPC: begin
            r.wb      = 1'b1;
            r.wb_data = pc + {instr[31:12], 12'b0};
        end
        default: r.illegal = 1'b1;                  // Loads, stores, fences, system
    endcase
    if (r.illegal) begin
        r.wb   = 1'b0;
        r.jump = 1'b0;
    end
    return r;
endfunction

`endif

/* dv/exec_tb.sv */
`timescale 1ns/10ps

module exec_tb
    import exec_pkg::*;
();

    `include "exec_tb_ref.svh"

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int TOTAL_INSTR  = 99;   // 57 + 18 + 6 + 6 + 4 + 8 over the six tests

    typedef struct packed {
        exp_t        res;
        logic [31:0] cyc;       // Cycle of i_valid
        logic        lat;       // Exact latency expected
    } sb_entry_t;

    logic        i_clk;
    logic        i_arst_n;
    logic        i_valid;
    logic [31:0] i_instr;
    logic [31:0] i_rs1_val;
    logic [31:0] i_rs2_val;
    logic [31:0] i_pc;
    logic        i_stall;
    logic        o_wb_valid;
    logic [31:0] o_wb_data;
    logic        o_jump_valid;
    logic [31:0] o_jump_addr;
    logic        o_illegal;
    logic        o_full;
    sb_entry_t   res_q[$];
    int unsigned ill_q[$];
    int unsigned cyc = 0;
    int unsigned checks = 0;
    int unsigned errors = 0;
    logic        check_lat = 1'b0;

    exec_top i_dut (.*);

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    always @(posedge i_clk) cyc <= cyc + 1;

    initial begin
        #((TOTAL_INSTR * 20 + RESET_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired before all tests completed");
        $display("Simulation FAILED");
        $finish;
    end

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
            errors++;
        end
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        errors++;
    endtask

    function automatic logic [31:0] enc_ri(input logic [11:0] hi, input logic [2:0] f3,
                                           input logic [6:0] opc);
        return {hi, 5'd1, f3, 5'd3, opc};       // funct7 and rs2, or imm12
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [2:0] f3);
        return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [6:0] opc);
        return {imm, 5'd1, opc};
    endfunction

    // One instruction on a falling edge, expected result queued
    task automatic present(input logic [31:0] instr, input logic [31:0] rs1,
                           input logic [31:0] rs2, input logic [31:0] pc);
        sb_entry_t e;
        while (o_full) @(negedge i_clk);
        i_valid   = 1'b1;
        i_instr   = instr;
        i_rs1_val = rs1;
        i_rs2_val = rs2;
        i_pc      = pc;
        e.res     = ref_result(instr, rs1, rs2, pc);
        e.cyc     = cyc;
        e.lat     = check_lat;
        if (e.res.illegal) begin
            ill_q.push_back(cyc);
        end else if (e.res.wb || e.res.jump) begin
            res_q.push_back(e);                 // Untaken branches leave nothing
        end
        @(negedge i_clk);
        i_valid = 1'b0;
    endtask

    task automatic finish_test(input string name);
        int n;
        n = 0;
        while ((res_q.size() != 0 || ill_q.size() != 0) && n < 40) begin
            @(negedge i_clk);
            n++;
        end
        if (res_q.size() != 0 || ill_q.size() != 0) begin
            report_error($sformatf("%0d results and %0d illegal strobes never arrived",
                                   res_q.size(), ill_q.size()));
            res_q.delete();
            ill_q.delete();
        end
        repeat (4) @(negedge i_clk);            // Room for stray strobes
        $display("Test %s finished, errors so far %0d", name, errors);
    endtask

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge i_clk) begin : compare_outputs
        sb_entry_t   e;
        int unsigned c;
        if (o_illegal) begin
            if (ill_q.size() == 0) begin
                report_error("o_illegal strobe with no illegal instruction pending");
            end else begin
                c = ill_q.pop_front();
                check_val("o_illegal cycle", c + 1, cyc);
            end
        end
        if (o_wb_valid || o_jump_valid) begin
            if (res_q.size() == 0) begin
                report_error("result strobe with no result expected");
            end else begin
                e = res_q.pop_front();
                check_val("o_wb_valid", e.res.wb, o_wb_valid);
                check_val("o_jump_valid", e.res.jump, o_jump_valid);
                if (e.res.wb && o_wb_valid) begin
                    check_val("o_wb_data", e.res.wb_data, o_wb_data);
                end
                if (e.res.jump && o_jump_valid) begin
                    check_val("o_jump_addr", e.res.jump_addr, o_jump_addr);
                end
                if (e.lat) begin
                    check_val("result cycle", e.cyc + 2, cyc);
                end
            end
        end
    end

    initial begin : main_seq
        logic [2:0]  f3;
        logic [31:0] imm;
        int          n;
        void'($urandom(32'h17486862));
        i_arst_n  = 1'b0;
        i_valid   = 1'b0;
        i_instr   = '0;
        i_rs1_val = '0;
        i_rs2_val = '0;
        i_pc      = '0;
        i_stall   = 1'b0;
        repeat (RESET_CYCLES) @(negedge i_clk);
        i_arst_n = 1'b1;
        @(negedge i_clk);
        if (o_wb_valid || o_jump_valid || o_illegal || o_full) begin
            report_error("strobes or o_full not low after reset");
        end

        for (int k = 0; k < 24; k++) begin
            f3 = $urandom % 8;
            imm = ((f3 == 3'd0 || f3 == 3'd5) && ($urandom % 2)) ? 32'h20 : 32'h0;
            present(enc_ri({imm[6:0], 5'd2}, f3, OPC_OP), $urandom, $urandom, 0);
        end
        for (int k = 0; k < 24; k++) begin
            f3  = $urandom % 8;
            imm = $urandom;
            if (f3 == 3'd1) begin
                imm[11:5] = 7'h00;
            end
            if (f3 == 3'd5) begin
                imm[11:5] = imm[10] ? 7'h20 : 7'h00;    // SRAI or SRLI
            end
            present(enc_ri(imm[11:0], f3, OPC_OPIMM), $urandom, 0, 0);
        end
        present(enc_ri({7'h00, 5'd2}, 3'd1, OPC_OP), 32'h8000_0001, 32'd0, 0);
        present(enc_ri({7'h00, 5'd2}, 3'd1, OPC_OP), 32'h8000_0001, 32'd31, 0);
        present(enc_ri({7'h20, 5'd2}, 3'd5, OPC_OP), 32'h8000_0000, 32'd31, 0);
        present(enc_ri({7'h00, 5'd2}, 3'd5, OPC_OP), 32'h8000_0000, 32'hffff_ffff, 0);
        present(enc_ri({7'h20, 5'd0}, 3'd5, OPC_OPIMM), 32'h8000_0000, 0, 0);
        present(enc_ri({7'h00, 5'd2}, 3'd2, OPC_OP), 32'h8000_0000, 32'h7fff_ffff, 0);
        present(enc_ri({7'h00, 5'd2}, 3'd3, OPC_OP), 32'h8000_0000, 32'h7fff_ffff, 0);
        present(enc_ri(12'hfff, 3'd2, OPC_OPIMM), 32'd0, 0, 0);  // Zero below -1 is false
        present(enc_ri(12'hfff, 3'd3, OPC_OPIMM), 32'd0, 0, 0);  // Unsigned view of -1
        finish_test("1 register and immediate ops");

        for (int j = 0; j < 8; j++) begin
            if (j != 2 && j != 3) begin
                present(enc_b($urandom, j), 32'd5, 32'd5, $urandom & 32'hffff_fffc);
                present(enc_b($urandom, j), -32'sd1, 32'd1, $urandom & 32'hffff_fffc);
                present(enc_b($urandom, j), 32'd1, -32'sd1, $urandom & 32'hffff_fffc);
            end
        end
        finish_test("2 branches");

        present(enc_j($urandom), 0, 0, $urandom & 32'hffff_fffc);
        present(enc_j($urandom), 0, 0, $urandom & 32'hffff_fffc);
        present(enc_ri(12'h010, 3'd0, OPC_JALR), 32'h0000_1001, 0, $urandom & 32'hffff_fffc);
        present(enc_ri($urandom, 3'd0, OPC_JALR), $urandom, 0, $urandom & 32'hffff_fffc);
        present(enc_u($urandom, OPC_LUI), 0, 0, $urandom & 32'hffff_fffc);
        present(enc_u($urandom, OPC_AUIPC), 0, 0, $urandom & 32'hffff_fffc);
        finish_test("3 jumps and upper immediates");

        present(enc_ri(12'h004, 3'd0, OPC_OPIMM), 32'd7, 0, 0);
        present(enc_ri(12'h010, 3'd2, 7'b0000011), 32'd7, 0, 0);      // LW
        present(enc_ri(12'h010, 3'd2, 7'b0100011), 32'd7, 32'd9, 0);  // SW
        present(enc_ri({7'h01, 5'd2}, 3'd0, OPC_OP), 32'd7, 32'd9, 0); // MUL
        present(enc_ri(12'h0ff, 3'd0, 7'b0001111), 0, 0, 0);          // FENCE
        present(enc_ri({7'h00, 5'd2}, 3'd0, OPC_OP), 32'd7, 32'd9, 0);
        finish_test("4 illegal instructions");

        i_stall = 1'b1;
        for (int k = 0; k < 4; k++) begin
            present(enc_ri({7'h00, 5'd2}, $urandom, OPC_OP), $urandom, $urandom, 0);
        end
        n = 0;
        while (!o_full && n < 8) begin
            @(negedge i_clk);
            n++;
        end
        if (!o_full) begin
            report_error("o_full did not rise with four entries held");
        end
        if (res_q.size() != 4) begin
            report_error("results left the queue while stalled");
        end
        i_stall = 1'b0;
        finish_test("5 stall and order");

        check_lat = 1'b1;
        for (int k = 0; k < 7; k++) begin
            present(enc_ri({7'h00, 5'd2}, $urandom, OPC_OP), $urandom, $urandom, 0);
        end
        present(enc_j($urandom), 0, 0, $urandom & 32'hffff_fffc);
        check_lat = 1'b0;
        finish_test("6 latency without stall");

        $display("Tests done: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+source
+incdir+dv
source/exec_pkg.sv
source/exec_op_if.sv
source/instr_decoder.sv
source/issue_fifo.sv
source/exec_alu.sv
source/exec_top.sv
dv/exec_tb.sv

/* source/exec_alu.sv */
`timescale 1ns/10ps
`include "exec_settings.svh"

module exec_alu
    import exec_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    exec_op_if.consumer           iss_if,
    output logic                  o_wb_valid,
    output logic [`EXEC_XLEN-1:0] o_wb_data,
    output logic                  o_jump_valid,
    output logic [`EXEC_XLEN-1:0] o_jump_addr
);

    localparam logic [`EXEC_XLEN-1:0] INSTR_BYTES = 4;

    logic [4:0]            shamt;
    logic [`EXEC_XLEN-1:0] sum;
    logic [`EXEC_XLEN-1:0] link;
    logic [`EXEC_XLEN-1:0] br_target;
    logic [`EXEC_XLEN-1:0] jalr_target;
    logic                  eq;
    logic                  lt_s;
    logic                  lt_u;
    logic                  wb_en;
    logic [`EXEC_XLEN-1:0] wb_val;
    logic                  jump_en;
    logic [`EXEC_XLEN-1:0] jump_tgt;

    assign shamt = iss_if.opb[4:0];
    assign sum   = iss_if.opa + iss_if.opb;     // opb holds imm on I, J and U forms
    assign link  = iss_if.pc + INSTR_BYTES;
    assign eq    = (iss_if.opa == iss_if.opb);
    assign lt_s  = ($signed(iss_if.opa) < $signed(iss_if.opb));
    assign lt_u  = (iss_if.opa < iss_if.opb);

    assign br_target   = iss_if.pc + iss_if.imm;
    assign jalr_target = {sum[`EXEC_XLEN-1:1], 1'b0};   // rs1 + imm, bit 0 cleared

    always_comb begin
        wb_en    = 1'b1;
        wb_val   = sum;
        jump_en  = 1'b0;
        jump_tgt = br_target;
        case (iss_if.op)
            OP_ADD, OP_ADDI:   wb_val = sum;
            OP_SUB:            wb_val = iss_if.opa - iss_if.opb;
            OP_SLL, OP_SLLI:   wb_val = iss_if.opa << shamt;
            OP_SLT, OP_SLTI:   wb_val = {{(`EXEC_XLEN-1){1'b0}}, lt_s};
            OP_SLTU, OP_SLTIU: wb_val = {{(`EXEC_XLEN-1){1'b0}}, lt_u};
            OP_XOR, OP_XORI:   wb_val = iss_if.opa ^ iss_if.opb;
            OP_SRL, OP_SRLI:   wb_val = iss_if.opa >> shamt;
            OP_SRA, OP_SRAI:   wb_val = $signed(iss_if.opa) >>> shamt;
            OP_OR, OP_ORI:     wb_val = iss_if.opa | iss_if.opb;
            OP_AND, OP_ANDI:   wb_val = iss_if.opa & iss_if.opb;
            OP_BEQ: begin
                wb_en   = 1'b0;
                jump_en = eq;
            end
            OP_BNE: begin
                wb_en   = 1'b0;
                jump_en = !eq;
            end
            OP_BLT: begin
                wb_en   = 1'b0;
                jump_en = lt_s;
            end
            OP_BGE: begin
                wb_en   = 1'b0;
                jump_en = !lt_s;
            end
            OP_BLTU: begin
                wb_en   = 1'b0;
                jump_en = lt_u;
            end
            OP_BGEU: begin
                wb_en   = 1'b0;
                jump_en = !lt_u;
            end
            OP_JAL: begin
                wb_val  = link;
                jump_en = 1'b1;                 // Target is PC + J immediate
            end
            OP_JALR: begin
                wb_val   = link;
                jump_en  = 1'b1;
                jump_tgt = jalr_target;
            end
            OP_LUI, OP_AUIPC:  wb_val = sum;    // opa is zero or PC
            default:           wb_en  = 1'b0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_wb_valid   <= 1'b0;
            o_jump_valid <= 1'b0;
        end else begin
            o_wb_valid   <= iss_if.valid && wb_en;
            o_jump_valid <= iss_if.valid && jump_en;
        end
    end

    always_ff @(posedge i_clk) begin
        if (iss_if.valid) begin
            o_wb_data   <= wb_val;
            o_jump_addr <= jump_tgt;
        end
    end

endmodule

/* source/exec_op_if.sv */
`timescale 1ns/10ps
`include "exec_settings.svh"

interface exec_op_if
    import exec_pkg::*;
();

    logic                  valid;   // One cycle per operation
    alu_op_e               op;
    logic [`EXEC_XLEN-1:0] opa;     // rs1, PC or zero
    logic [`EXEC_XLEN-1:0] opb;     // rs2 or immediate
    logic [`EXEC_XLEN-1:0] pc;
    logic [`EXEC_XLEN-1:0] imm;     // Sign extended

    modport producer (
        output valid,
        output op,
        output opa,
        output opb,
        output pc,
        output imm
    );

    modport consumer (
        input valid,
        input op,
        input opa,
        input opb,
        input pc,
        input imm
    );

endinterface

/* source/exec_pkg.sv */
package exec_pkg;

    // Major opcodes handled by the execute slice
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    localparam logic [6:0] F7_BASE = 7'b0000000;    // ADD, SRL and the rest
    localparam logic [6:0] F7_ALT  = 7'b0100000;    // SUB, SRA

    typedef enum logic [4:0] {
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        OP_ADDI,
        OP_SLTI,
        OP_SLTIU,
        OP_XORI,
        OP_ORI,
        OP_ANDI,
        OP_SLLI,
        OP_SRLI,
        OP_SRAI,
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_JAL,
        OP_JALR,
        OP_LUI,
        OP_AUIPC,
        OP_NONE = 5'd31             // Nothing to execute
    } alu_op_e;

    // Same instruction word seen two ways. The ri view gives the register
    // fields, the bju view cuts the word where B, J and U immediates split.
    typedef union packed {
        struct packed {
            logic [6:0] funct7;     // Also imm[11:5] of I type
            logic [4:0] rs2;        // Also imm[4:0] or shamt
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } ri;
        struct packed {
            logic       sign;       // Bit 31
            logic [5:0] hi6;        // Bits 30:25
            logic [3:0] mid4;       // Bits 24:21
            logic       b20;
            logic [7:0] b19_12;
            logic [3:0] b11_8;
            logic       b7;
            logic [6:0] opcode;
        } bju;
    } rv_instr_u;

endpackage

/* source/exec_settings.svh */
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Datapath width of the execute slice
`define EXEC_XLEN 32

// Issue queue between decoder and ALU
`define EXEC_FIFO_DEPTH 4       // Entries
`define EXEC_FIFO_AW    2       // Pointer width, log2 of depth

`endif

/* source/exec_top.sv */
`timescale 1ns/10ps
`include "exec_settings.svh"

module exec_top (
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    input  logic                  i_valid,
    input  logic [31:0]           i_instr,
    input  logic [`EXEC_XLEN-1:0] i_rs1_val,
    input  logic [`EXEC_XLEN-1:0] i_rs2_val,
    input  logic [`EXEC_XLEN-1:0] i_pc,
    input  logic                  i_stall,
    output logic                  o_wb_valid,
    output logic [`EXEC_XLEN-1:0] o_wb_data,
    output logic                  o_jump_valid,
    output logic [`EXEC_XLEN-1:0] o_jump_addr,
    output logic                  o_illegal,
    output logic                  o_full
);

    exec_op_if dec_if ();       // Decoder to queue
    exec_op_if iss_if ();       // Queue to ALU

    instr_decoder i_decoder (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_valid   (i_valid),
        .i_instr   (i_instr),
        .i_rs1_val (i_rs1_val),
        .i_rs2_val (i_rs2_val),
        .i_pc      (i_pc),
        .o_illegal (o_illegal),
        .dec_if    (dec_if.producer)
    );

    issue_fifo i_fifo (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_stall  (i_stall),
        .dec_if   (dec_if.consumer),
        .iss_if   (iss_if.producer),
        .o_full   (o_full)
    );

    exec_alu i_alu (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .iss_if       (iss_if.consumer),
        .o_wb_valid   (o_wb_valid),
        .o_wb_data    (o_wb_data),
        .o_jump_valid (o_jump_valid),
        .o_jump_addr  (o_jump_addr)
    );

endmodule

/* source/instr_decoder.sv */
`timescale 1ns/10ps
`include "exec_settings.svh"

module instr_decoder
    import exec_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_arst_n,
    input  logic                  i_valid,
    input  rv_instr_u             i_instr,
    input  logic [`EXEC_XLEN-1:0] i_rs1_val,
    input  logic [`EXEC_XLEN-1:0] i_rs2_val,
    input  logic [`EXEC_XLEN-1:0] i_pc,
    output logic                  o_illegal,
    exec_op_if.producer           dec_if
);

    logic [`EXEC_XLEN-1:0] imm_i;
    logic [`EXEC_XLEN-1:0] imm_b;
    logic [`EXEC_XLEN-1:0] imm_j;
    logic [`EXEC_XLEN-1:0] imm_u;
    logic [2:0]            funct3;
    logic                  f7_base;
    logic                  f7_alt;
    alu_op_e               op_d;
    logic                  legal_d;
    logic [`EXEC_XLEN-1:0] opa_d;
    logic [`EXEC_XLEN-1:0] opb_d;
    logic [`EXEC_XLEN-1:0] imm_d;

    assign funct3  = i_instr.ri.funct3;
    assign f7_base = (i_instr.ri.funct7 == F7_BASE);
    assign f7_alt  = (i_instr.ri.funct7 == F7_ALT);

    assign imm_i = {{(`EXEC_XLEN-12){i_instr.ri.funct7[6]}}, i_instr.ri.funct7, i_instr.ri.rs2};
    assign imm_b = {{(`EXEC_XLEN-12){i_instr.bju.sign}}, i_instr.bju.b7, i_instr.bju.hi6,
                    i_instr.bju.b11_8, 1'b0};
    assign imm_j = {{(`EXEC_XLEN-20){i_instr.bju.sign}}, i_instr.bju.b19_12, i_instr.bju.b20,
                    i_instr.bju.hi6, i_instr.bju.mid4, 1'b0};
    assign imm_u = {i_instr.bju.sign, i_instr.bju.hi6, i_instr.bju.mid4, i_instr.bju.b20,
                    i_instr.bju.b19_12, 12'b0};     // Low 12 bits always zero

    always_comb begin
        op_d    = OP_NONE;
        legal_d = 1'b0;
        opa_d   = i_rs1_val;
        opb_d   = imm_i;
        imm_d   = imm_i;
        case (i_instr.ri.opcode)
            OPC_OP: begin
                opb_d = i_rs2_val;
                imm_d = '0;
                case (funct3)
                    3'b000:  op_d = f7_alt ? OP_SUB : OP_ADD;
                    3'b001:  op_d = OP_SLL;
                    3'b010:  op_d = OP_SLT;
                    3'b011:  op_d = OP_SLTU;
                    3'b100:  op_d = OP_XOR;
                    3'b101:  op_d = f7_alt ? OP_SRA : OP_SRL;
                    3'b110:  op_d = OP_OR;
                    default: op_d = OP_AND;
                endcase
                // Alternate funct7 only valid on SUB and SRA, MUL group rejected here
                legal_d = f7_base || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            OPC_OPIMM: begin
                case (funct3)
                    3'b000:  op_d = OP_ADDI;
                    3'b001:  op_d = OP_SLLI;
                    3'b010:  op_d = OP_SLTI;
                    3'b011:  op_d = OP_SLTIU;
                    3'b100:  op_d = OP_XORI;
                    3'b101:  op_d = f7_alt ? OP_SRAI : OP_SRLI;
                    3'b110:  op_d = OP_ORI;
                    default: op_d = OP_ANDI;
                endcase
                if (funct3 == 3'b001) begin
                    legal_d = f7_base;
                end else if (funct3 == 3'b101) begin
                    legal_d = f7_base || f7_alt;
                end else begin
                    legal_d = 1'b1;
                end
            end
            OPC_BRANCH: begin
                opb_d   = i_rs2_val;
                imm_d   = imm_b;
                legal_d = 1'b1;
                case (funct3)
                    3'b000:  op_d = OP_BEQ;
                    3'b001:  op_d = OP_BNE;
                    3'b100:  op_d = OP_BLT;
                    3'b101:  op_d = OP_BGE;
                    3'b110:  op_d = OP_BLTU;
                    3'b111:  op_d = OP_BGEU;
                    default: legal_d = 1'b0;    // 010 and 011 unused
                endcase
            end
            OPC_JAL: begin
                op_d    = OP_JAL;
                legal_d = 1'b1;
                opa_d   = i_pc;
                opb_d   = imm_j;
                imm_d   = imm_j;
            end
            OPC_JALR: begin
                op_d    = OP_JALR;
                legal_d = (funct3 == 3'b000);
            end
            OPC_LUI: begin
                op_d    = OP_LUI;
                legal_d = 1'b1;
                opa_d   = '0;
                opb_d   = imm_u;
                imm_d   = imm_u;
            end
            OPC_AUIPC: begin
                op_d    = OP_AUIPC;
                legal_d = 1'b1;
                opa_d   = i_pc;
                opb_d   = imm_u;
                imm_d   = imm_u;
            end
            default: legal_d = 1'b0;            // Loads, stores, fences, CSRs
        endcase
        if (!legal_d) begin
            op_d = OP_NONE;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            dec_if.valid <= 1'b0;
            o_illegal    <= 1'b0;
        end else begin
            dec_if.valid <= i_valid && legal_d;
            o_illegal    <= i_valid && !legal_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            dec_if.op  <= op_d;
            dec_if.opa <= opa_d;
            dec_if.opb <= opb_d;
            dec_if.pc  <= i_pc;
            dec_if.imm <= imm_d;
        end
    end

endmodule

/* source/issue_fifo.sv */
`timescale 1ns/10ps
`include "exec_settings.svh"

module issue_fifo
    import exec_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_arst_n,
    input  logic        i_stall,
    exec_op_if.consumer dec_if,
    exec_op_if.producer iss_if,
    output logic        o_full
);

    alu_op_e                  mem_op  [`EXEC_FIFO_DEPTH];
    logic [`EXEC_XLEN-1:0]    mem_opa [`EXEC_FIFO_DEPTH];
    logic [`EXEC_XLEN-1:0]    mem_opb [`EXEC_FIFO_DEPTH];
    logic [`EXEC_XLEN-1:0]    mem_pc  [`EXEC_FIFO_DEPTH];
    logic [`EXEC_XLEN-1:0]    mem_imm [`EXEC_FIFO_DEPTH];
    logic [`EXEC_FIFO_AW-1:0] wr_ptr;
    logic [`EXEC_FIFO_AW-1:0] rd_ptr;
    logic [`EXEC_FIFO_AW:0]   count;    // 0 to depth inclusive
    logic                     empty;
    logic                     push;
    logic                     pop;

    assign empty  = (count == '0);
    assign o_full = (count == `EXEC_FIFO_DEPTH);

    // An empty queue passes the incoming entry straight to the head
    assign pop  = !i_stall && (!empty || dec_if.valid);
    assign push = dec_if.valid && (!o_full || pop);    // Dropped when full and held

    assign iss_if.valid = pop;
    assign iss_if.op    = empty ? dec_if.op  : mem_op[rd_ptr];
    assign iss_if.opa   = empty ? dec_if.opa : mem_opa[rd_ptr];
    assign iss_if.opb   = empty ? dec_if.opb : mem_opb[rd_ptr];
    assign iss_if.pc    = empty ? dec_if.pc  : mem_pc[rd_ptr];
    assign iss_if.imm   = empty ? dec_if.imm : mem_imm[rd_ptr];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;                      // Bypass or idle, level unchanged
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (push) begin
            mem_op[wr_ptr]  <= dec_if.op;
            mem_opa[wr_ptr] <= dec_if.opa;
            mem_opb[wr_ptr] <= dec_if.opb;
            mem_pc[wr_ptr]  <= dec_if.pc;
            mem_imm[wr_ptr] <= dec_if.imm;
        end
    end

endmodule
